/* src/comm_pkg.sv */
`default_nettype none

package comm_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int WORD_W  = 32;
	localparam int ADDR_W  = 27;
	localparam int COUNT_W = 12;
	localparam int DEV_W   = 3;

	// sync exchange
	localparam logic [WORD_W-1:0] KEY_SYNC = 32'h4A78B9F2;
	localparam logic [WORD_W-1:0] XOR_SYNC = 32'hCD0031F7;

	// startup purge length in consecutive empty cycles
	localparam int PURGE_CYCLES = 20000;
	localparam int PURGE_W      = $clog2(PURGE_CYCLES);

	// byte address advance per word
	localparam int ADDR_STEP = 4;

	// ----------------------------------------------------------------------
	// header word layout
	// ----------------------------------------------------------------------
	localparam int HDR_CFG_BIT = 14;
	localparam int HDR_CNT_BIT = 13;
	localparam int HDR_WR_BIT  = 12;
	localparam int HDR_DEV_LSB = 24;
	localparam int CFG_DATA_W  = 2;

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_CONFIG} cmd_op_e;

	typedef enum logic [1:0] {LINK_PURGE, LINK_SYNC, LINK_ACTIVE} link_state_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_HEADER,
		SEQ_ADDRESS,
		SEQ_GET_DATA,
		SEQ_MEM_WAIT,
		SEQ_SEND_WORD,
		SEQ_ACK,
		SEQ_ERROR
	} seq_state_e;

	// host fifo strobes plus outgoing word
	typedef struct packed {
		logic              rx_read;
		logic              tx_write;
		logic [WORD_W-1:0] tx_data;
	} host_xfer_t;

	// one memory access request
	typedef struct packed {
		logic              start;
		cmd_op_e           op;
		logic              load_addr;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic [DEV_W-1:0]  dev;
	} mem_cmd_t;

	typedef struct packed {
		logic              finished;
		logic [WORD_W-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* src/host_link.sv */
`timescale 1ns/100ps
`default_nettype none

module host_link import comm_pkg::*; (
	input  wire                clock_i,
	input  wire                resetn_i,
	input  wire                rx_empty_i,
	input  wire                tx_full_i,
	input  wire [WORD_W-1:0]   rx_data_i,
	input  wire host_xfer_t    seq_xfer_i,
	output logic               link_ready_o,
	output logic               rx_read_o,
	output logic               tx_write_o,
	output logic [WORD_W-1:0]  tx_data_o
);

	link_state_e        state_q;
	logic [PURGE_W-1:0] purge_cnt_q;
	logic               sync_take;
	logic               sync_key;

	// a sync word only moves when its echo can go out in the same cycle
	assign sync_take    = !rx_empty_i && !tx_full_i;
	assign sync_key     = (rx_data_i == KEY_SYNC);
	assign link_ready_o = (state_q == LINK_ACTIVE);

	// ----------------------------------------------------------------------
	// link state and purge timer
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= LINK_PURGE;
			purge_cnt_q <= '0;
		end else begin
			case (state_q)
				LINK_PURGE: begin
					// any word restarts the quiet period
					if (!rx_empty_i) begin
						purge_cnt_q <= '0;
					end else if (purge_cnt_q == PURGE_W'(PURGE_CYCLES - 1)) begin
						state_q <= LINK_SYNC;
					end else begin
						purge_cnt_q <= purge_cnt_q + 1'b1;
					end
				end
				LINK_SYNC: begin
					if (sync_take && sync_key) begin
						state_q <= LINK_ACTIVE;
					end
				end
				LINK_ACTIVE: begin
					// held until reset
				end
				default: begin
					state_q <= LINK_PURGE;
				end
			endcase
		end
	end

	// fifo port ownership
	always_comb begin
		rx_read_o  = 1'b0;
		tx_write_o = 1'b0;
		tx_data_o  = rx_data_i ^ XOR_SYNC;
		case (state_q)
			LINK_PURGE: begin
				rx_read_o = !rx_empty_i;
			end
			LINK_SYNC: begin
				rx_read_o  = sync_take;
				tx_write_o = sync_take && !sync_key;
			end
			LINK_ACTIVE: begin
				rx_read_o  = seq_xfer_i.rx_read;
				tx_write_o = seq_xfer_i.tx_write;
				tx_data_o  = seq_xfer_i.tx_data;
			end
			default: begin
			end
		endcase
	end

	// strobes from either owner must respect fifo levels
	rx_read_guard: assert property (@(posedge clock_i) disable iff (!resetn_i)
		rx_empty_i |-> !rx_read_o)
		else $error("rx_read_o raised while rx fifo empty");

	tx_write_guard: assert property (@(posedge clock_i) disable iff (!resetn_i)
		tx_full_i |-> !tx_write_o)
		else $error("tx_write_o raised while tx fifo full");

endmodule

`default_nettype wire

/* src/command_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module command_sequencer import comm_pkg::*; (
	input  wire               clock_i,
	input  wire               resetn_i,
	input  wire               link_ready_i,
	input  wire               rx_empty_i,
	input  wire               tx_full_i,
	input  wire [WORD_W-1:0]  rx_data_i,
	output host_xfer_t        xfer_o,
	output mem_cmd_t          mem_cmd_o,
	input  wire mem_rsp_t     mem_rsp_i,
	output logic              exception_o
);

	seq_state_e         state_q;
	cmd_op_e            op_q;
	logic [COUNT_W-1:0] count_q;
	logic               take;
	logic               give;
	logic               last_word;
	cmd_op_e            hdr_op;
	logic [COUNT_W-1:0] hdr_count;

	assign take      = link_ready_i && !rx_empty_i;
	assign give      = link_ready_i && !tx_full_i;
	assign last_word = (count_q == COUNT_W'(1));

	// header decode
	always_comb begin
		if (rx_data_i[HDR_CFG_BIT]) begin
			hdr_op = OP_CONFIG;
		end else if (rx_data_i[HDR_WR_BIT]) begin
			hdr_op = OP_WRITE;
		end else begin
			hdr_op = OP_READ;
		end
		hdr_count = rx_data_i[HDR_CNT_BIT] ? rx_data_i[COUNT_W-1:0] : COUNT_W'(1);
	end

	// ----------------------------------------------------------------------
	// command fsm
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= SEQ_IDLE;
			op_q        <= OP_READ;
			count_q     <= '0;
			exception_o <= 1'b0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					// terminator must be zero
					if (take) begin
						if (rx_data_i != '0) begin
							state_q     <= SEQ_ERROR;
							exception_o <= 1'b1;
						end else begin
							state_q <= SEQ_HEADER;
						end
					end
				end
				SEQ_HEADER: begin
					if (take) begin
						op_q    <= hdr_op;
						count_q <= hdr_count;
						state_q <= (hdr_op == OP_CONFIG) ? SEQ_MEM_WAIT : SEQ_ADDRESS;
					end
				end
				SEQ_ADDRESS: begin
					// reads start right away while writes need a data word first
					if (take) begin
						state_q <= (op_q == OP_WRITE) ? SEQ_GET_DATA : SEQ_MEM_WAIT;
					end
				end
				SEQ_GET_DATA: begin
					if (take) begin
						state_q <= SEQ_MEM_WAIT;
					end
				end
				SEQ_MEM_WAIT: begin
					if (mem_rsp_i.finished) begin
						if (op_q == OP_READ) begin
							state_q <= SEQ_SEND_WORD;
						end else if (op_q == OP_WRITE && !last_word) begin
							count_q <= count_q - 1'b1;
							state_q <= SEQ_GET_DATA;
						end else begin
							state_q <= SEQ_ACK;
						end
					end
				end
				SEQ_SEND_WORD: begin
					// next read goes out together with this word
					if (give) begin
						if (last_word) begin
							state_q <= SEQ_IDLE;
						end else begin
							count_q <= count_q - 1'b1;
							state_q <= SEQ_MEM_WAIT;
						end
					end
				end
				SEQ_ACK: begin
					if (give) begin
						state_q <= SEQ_IDLE;
					end
				end
				SEQ_ERROR: begin
					// sticky until reset
				end
				default: begin
					state_q <= SEQ_IDLE;
				end
			endcase
		end
	end

	// fifo and memory requests per state
	always_comb begin
		xfer_o              = '0;
		mem_cmd_o.start     = 1'b0;
		mem_cmd_o.op        = op_q;
		mem_cmd_o.load_addr = 1'b0;
		mem_cmd_o.addr      = rx_data_i[ADDR_W-1:0];
		mem_cmd_o.wdata     = rx_data_i;
		mem_cmd_o.dev       = rx_data_i[HDR_DEV_LSB +: DEV_W];
		case (state_q)
			SEQ_IDLE: begin
				xfer_o.rx_read = take;
			end
			SEQ_HEADER: begin
				xfer_o.rx_read = take;
				if (hdr_op == OP_CONFIG) begin
					mem_cmd_o.start = take;
					mem_cmd_o.op    = OP_CONFIG;
					mem_cmd_o.wdata = {{(WORD_W-CFG_DATA_W){1'b0}}, rx_data_i[CFG_DATA_W-1:0]};
				end
			end
			SEQ_ADDRESS: begin
				xfer_o.rx_read      = take;
				mem_cmd_o.load_addr = take;
				mem_cmd_o.start     = take && (op_q == OP_READ);
			end
			SEQ_GET_DATA: begin
				xfer_o.rx_read  = take;
				mem_cmd_o.start = take;
			end
			SEQ_SEND_WORD: begin
				xfer_o.tx_write = give;
				xfer_o.tx_data  = mem_rsp_i.rdata;
				mem_cmd_o.start = give && !last_word;
			end
			SEQ_ACK: begin
				xfer_o.tx_write = give;
			end
			default: begin
			end
		endcase
	end

	// one access in flight until the memory port's finished pulse
	single_access: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_cmd_o.start |=> (!mem_cmd_o.start until mem_rsp_i.finished))
		else $error("memory start raised while an access is pending");

	exception_sticky: assert property (@(posedge clock_i) disable iff (!resetn_i)
		exception_o |=> exception_o)
		else $error("exception_o fell without reset");

endmodule

`default_nettype wire

/* src/mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_port import comm_pkg::*; (
	input  wire                clock_i,
	input  wire                resetn_i,
	input  wire mem_cmd_t      cmd_i,
	output mem_rsp_t           rsp_o,
	input  wire                ready_i,
	input  wire                done_i,
	input  wire [WORD_W-1:0]   data_i,
	output logic               req_o,
	output logic               rw_o,
	output logic               clear_o,
	output logic [ADDR_W-1:0]  add_o,
	output logic [WORD_W-1:0]  data_o,
	output logic [DEV_W-1:0]   reqdev_o
);

	typedef enum logic [2:0] {
		MP_IDLE,
		MP_CONFIG,
		MP_WAIT_READY,
		MP_WAIT_DONE,
		MP_CLEAR
	} mp_state_e;

	mp_state_e         state_q;
	logic [ADDR_W-1:0] addr_q;
	logic [ADDR_W-1:0] access_addr;
	logic [WORD_W-1:0] rdata_q;
	logic              finished_q;
	logic              access_start;

	assign access_start = cmd_i.start && (cmd_i.op != OP_CONFIG) && (state_q == MP_IDLE);
	// a start with load uses the fresh address directly
	assign access_addr  = cmd_i.load_addr ? cmd_i.addr : addr_q;

	always_comb begin
		rsp_o.finished = finished_q;
		rsp_o.rdata    = rdata_q;
	end

	// address pointer and payload
	always_ff @(posedge clock_i) begin
		if (access_start) begin
			addr_q <= access_addr + ADDR_W'(ADDR_STEP);
			add_o  <= access_addr;
		end else if (cmd_i.load_addr) begin
			addr_q <= cmd_i.addr;
		end
		if (cmd_i.start && state_q == MP_IDLE) begin
			data_o <= cmd_i.wdata;
		end
		if (state_q == MP_WAIT_DONE && done_i && !rw_o) begin
			rdata_q <= data_i;
		end
	end

	// ----------------------------------------------------------------------
	// bus handshake
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= MP_IDLE;
			req_o      <= 1'b0;
			rw_o       <= 1'b0;
			clear_o    <= 1'b0;
			reqdev_o   <= '0;
			finished_q <= 1'b0;
		end else begin
			req_o      <= 1'b0;
			clear_o    <= 1'b0;
			reqdev_o   <= '0;
			finished_q <= 1'b0;
			case (state_q)
				MP_IDLE: begin
					if (cmd_i.start) begin
						// config skips the ready wait
						if (cmd_i.op == OP_CONFIG) begin
							req_o    <= 1'b1;
							reqdev_o <= cmd_i.dev;
							state_q  <= MP_CONFIG;
						end else begin
							rw_o    <= (cmd_i.op == OP_WRITE);
							state_q <= MP_WAIT_READY;
						end
					end
				end
				MP_CONFIG: begin
					finished_q <= 1'b1;
					state_q    <= MP_IDLE;
				end
				MP_WAIT_READY: begin
					if (ready_i) begin
						req_o   <= 1'b1;
						state_q <= MP_WAIT_DONE;
					end
				end
				MP_WAIT_DONE: begin
					if (done_i) begin
						clear_o <= 1'b1;
						state_q <= MP_CLEAR;
					end
				end
				MP_CLEAR: begin
					finished_q <= 1'b1;
					state_q    <= MP_IDLE;
				end
				default: begin
					state_q <= MP_IDLE;
				end
			endcase
		end
	end

	req_single_pulse: assert property (@(posedge clock_i) disable iff (!resetn_i)
		req_o |=> !req_o)
		else $error("req_o high for two cycles");

endmodule

`default_nettype wire

/* src/comm_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module comm_controller import comm_pkg::*; (
	input  wire                clock_i,
	input  wire                resetn_i,
	input  wire                tx_full_i,
	input  wire                rx_empty_i,
	input  wire [WORD_W-1:0]   rx_data_i,
	output logic               rx_read_o,
	output logic               tx_write_o,
	output logic [WORD_W-1:0]  tx_data_o,
	input  wire                ready_i,
	input  wire                done_i,
	input  wire [WORD_W-1:0]   data_i,
	output logic [DEV_W-1:0]   reqdev_o,
	output logic               req_o,
	output logic               rw_o,
	output logic [ADDR_W-1:0]  add_o,
	output logic [WORD_W-1:0]  data_o,
	output logic               clear_o,
	output logic               exception_o
);

	host_xfer_t seq_xfer;
	logic       link_ready;
	mem_cmd_t   mem_cmd;
	mem_rsp_t   mem_rsp;

	// ----------------------------------------------------------------------
	// host side
	// ----------------------------------------------------------------------
	host_link link_i (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.rx_empty_i   (rx_empty_i),
		.tx_full_i    (tx_full_i),
		.rx_data_i    (rx_data_i),
		.seq_xfer_i   (seq_xfer),
		.link_ready_o (link_ready),
		.rx_read_o    (rx_read_o),
		.tx_write_o   (tx_write_o),
		.tx_data_o    (tx_data_o)
	);

	command_sequencer seq_i (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.link_ready_i (link_ready),
		.rx_empty_i   (rx_empty_i),
		.tx_full_i    (tx_full_i),
		.rx_data_i    (rx_data_i),
		.xfer_o       (seq_xfer),
		.mem_cmd_o    (mem_cmd),
		.mem_rsp_i    (mem_rsp),
		.exception_o  (exception_o)
	);

	// memory bus side
	mem_port mem_i (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.cmd_i    (mem_cmd),
		.rsp_o    (mem_rsp),
		.ready_i  (ready_i),
		.done_i   (done_i),
		.data_i   (data_i),
		.req_o    (req_o),
		.rw_o     (rw_o),
		.clear_o  (clear_o),
		.add_o    (add_o),
		.data_o   (data_o),
		.reqdev_o (reqdev_o)
	);

endmodule

`default_nettype wire

/* testbench/mem_responder.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_responder import comm_pkg::*; (
	input  wire                clock_i,
	input  wire                resetn_i,
	input  wire                req_i,
	input  wire                rw_i,
	input  wire                clear_i,
	input  wire [ADDR_W-1:0]   add_i,
	input  wire [WORD_W-1:0]   data_i,
	input  wire [DEV_W-1:0]    reqdev_i,
	output logic               ready_o,
	output logic               done_o,
	output logic [WORD_W-1:0]  data_o
);

	logic [WORD_W-1:0] mem [logic [ADDR_W-1:0]];
	int                cfg_count;
	integer            seed;
	int                delay;
	logic              busy;

	// untouched locations read back a pattern of their own address
	function automatic logic [WORD_W-1:0] background_word(input logic [ADDR_W-1:0] addr);
		return {addr[4:0], addr} ^ 32'h9E37_79B9;
	endfunction

	initial begin
		seed      = 94;
		cfg_count = 0;
		delay     = 0;
		busy      = 1'b0;
		ready_o   = 1'b0;
		done_o    = 1'b0;
		data_o    = '0;
	end

	// ----------------------------------------------------------------------
	// bus answers driven on the falling edge
	// ----------------------------------------------------------------------
	always @(negedge clock_i) begin
		if (!resetn_i) begin
			busy    = 1'b0;
			ready_o = 1'b0;
			done_o  = 1'b0;
		end else if (req_i && reqdev_i != '0) begin
			// config request without a done handshake
			cfg_count++;
		end else if (req_i) begin
			if (rw_i) begin
				mem[add_i] = data_i;
			end else begin
				data_o = mem.exists(add_i) ? mem[add_i] : background_word(add_i);
			end
			busy    = 1'b1;
			ready_o = 1'b0;
			delay   = 1 + int'({$random(seed)} % 5);
		end else if (busy && !done_o) begin
			delay--;
			if (delay == 0) begin
				done_o = 1'b1;
			end
		end else if (done_o && clear_i) begin
			done_o = 1'b0;
			busy   = 1'b0;
		end else if (!busy) begin
			// ready about three cycles in four
			ready_o = ({$random(seed)} % 4) != 0;
		end
	end

endmodule

`default_nettype wire

/* testbench/comm_controller_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module comm_controller_tb import comm_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	localparam int SYNC_WORDS   = 12;
	localparam int NUM_WRITES   = 20;
	localparam int NUM_READS    = 20;
	localparam int NUM_CONFIGS  = 8;
	localparam int NUM_MIXED    = 30;
	localparam int NUM_CMDS     = NUM_WRITES + NUM_READS + NUM_CONFIGS + NUM_MIXED + 1;
	// worst case cycles for one command of up to eight words
	localparam int CMD_BOUND    = 300;
	localparam int RUN_CYCLES   = PURGE_CYCLES + 2000 + NUM_CMDS * CMD_BOUND;

	localparam int KIND_WRITE  = 0;
	localparam int KIND_READ   = 1;
	localparam int KIND_CONFIG = 2;
	localparam int KIND_MIXED  = 3;

	typedef struct packed {
		logic              is_cfg;
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic [DEV_W-1:0]  dev;
	} bus_op_t;

	logic              clock_i;
	logic              resetn_i;
	logic              tx_full_i;
	logic              rx_empty_i;
	logic [WORD_W-1:0] rx_data_i;
	logic              rx_read_o;
	logic              tx_write_o;
	logic [WORD_W-1:0] tx_data_o;
	logic              ready_i;
	logic              done_i;
	logic [WORD_W-1:0] data_i;
	logic [DEV_W-1:0]  reqdev_o;
	logic              req_o;
	logic              rw_o;
	logic [ADDR_W-1:0] add_o;
	logic [WORD_W-1:0] data_o;
	logic              clear_o;
	logic              exception_o;

	integer            seed = 94;
	int                errors = 0;
	int                tests_run = 0;
	int                tests_failed = 0;
	int                tx_count = 0;
	int                tx_pushed = 0;
	int                bus_count = 0;
	int                bus_pushed = 0;
	int                clear_count = 0;
	int                cfg_sent = 0;
	logic [WORD_W-1:0] rx_q[$];
	logic [WORD_W-1:0] tx_exp_q[$];
	bus_op_t           bus_exp_q[$];
	logic [ADDR_W-1:0] written_q[$];
	logic [WORD_W-1:0] model_mem [logic [ADDR_W-1:0]];
	logic [WORD_W-1:0] tx_expected;
	bus_op_t           bus_expected;

	comm_controller dut_i (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.tx_full_i   (tx_full_i),
		.rx_empty_i  (rx_empty_i),
		.rx_data_i   (rx_data_i),
		.rx_read_o   (rx_read_o),
		.tx_write_o  (tx_write_o),
		.tx_data_o   (tx_data_o),
		.ready_i     (ready_i),
		.done_i      (done_i),
		.data_i      (data_i),
		.reqdev_o    (reqdev_o),
		.req_o       (req_o),
		.rw_o        (rw_o),
		.add_o       (add_o),
		.data_o      (data_o),
		.clear_o     (clear_o),
		.exception_o (exception_o)
	);

	mem_responder responder_i (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.req_i    (req_o),
		.rw_i     (rw_o),
		.clear_i  (clear_o),
		.add_i    (add_o),
		.data_i   (data_o),
		.reqdev_i (reqdev_o),
		.ready_o  (ready_i),
		.done_o   (done_i),
		.data_o   (data_i)
	);

	always #(CLK_PERIOD / 2) clock_i = !clock_i;

	// ----------------------------------------------------------------------
	// checking helpers and reference model
	// ----------------------------------------------------------------------
	task automatic check_value(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] expected);
		assert (got === expected) else begin
			$display("[FAIL] %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond) else begin
			$display("error: %s", what);
			errors++;
		end
	endtask

	// same fill as the memory model for untouched locations
	function automatic logic [WORD_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
		if (model_mem.exists(addr)) begin
			return model_mem[addr];
		end
		return {addr[4:0], addr} ^ 32'h9E37_79B9;
	endfunction

	function automatic logic [ADDR_W-1:0] pick_address();
		logic [ADDR_W-1:0] addr;
		// half the time revisit a written address
		if (written_q.size() != 0 && ($random(seed) & 1) != 0) begin
			addr = written_q[{$random(seed)} % written_q.size()];
		end else begin
			addr      = $random(seed);
			addr[1:0] = 2'b00;
		end
		return addr;
	endfunction

	function automatic logic [WORD_W-1:0] rw_header(input logic write, input int count);
		logic [WORD_W-1:0] header;
		header              = $random(seed);
		header[HDR_CFG_BIT] = 1'b0;
		header[HDR_WR_BIT]  = write;
		// a single word may leave the count field out
		if (count != 1 || header[0]) begin
			header[HDR_CNT_BIT]  = 1'b1;
			header[COUNT_W-1:0]  = COUNT_W'(count);
		end else begin
			header[HDR_CNT_BIT] = 1'b0;
		end
		return header;
	endfunction

	task automatic expect_tx(input logic [WORD_W-1:0] word);
		tx_exp_q.push_back(word);
		tx_pushed++;
	endtask

	task automatic expect_bus(input bus_op_t op);
		bus_exp_q.push_back(op);
		bus_pushed++;
	endtask

	task automatic queue_write(input logic [ADDR_W-1:0] addr, input int count);
		logic [WORD_W-1:0] word;
		logic [ADDR_W-1:0] a;
		int                i;
		rx_q.push_back('0);
		rx_q.push_back(rw_header(1'b1, count));
		rx_q.push_back({{(WORD_W-ADDR_W){1'b0}}, addr});
		a = addr;
		for (i = 0; i < count; i++) begin
			word = $random(seed);
			rx_q.push_back(word);
			expect_bus('{1'b0, 1'b1, a, word, '0});
			model_mem[a] = word;
			written_q.push_back(a);
			a = a + ADDR_W'(ADDR_STEP);
		end
		expect_tx('0);
	endtask

	task automatic queue_read(input logic [ADDR_W-1:0] addr, input int count);
		logic [ADDR_W-1:0] a;
		int                i;
		rx_q.push_back('0);
		rx_q.push_back(rw_header(1'b0, count));
		rx_q.push_back({{(WORD_W-ADDR_W){1'b0}}, addr});
		a = addr;
		for (i = 0; i < count; i++) begin
			expect_bus('{1'b0, 1'b0, a, '0, '0});
			expect_tx(model_word(a));
			a = a + ADDR_W'(ADDR_STEP);
		end
	endtask

	task automatic queue_config();
		logic [WORD_W-1:0] header;
		logic [DEV_W-1:0]  dev;
		dev                          = DEV_W'(1 + {$random(seed)} % 7);
		header                       = $random(seed);
		header[HDR_CFG_BIT]          = 1'b1;
		header[HDR_DEV_LSB +: DEV_W] = dev;
		rx_q.push_back('0);
		rx_q.push_back(header);
		expect_bus('{1'b1, 1'b0, '0, {30'b0, header[1:0]}, dev});
		expect_tx('0);
		cfg_sent++;
	endtask

	task automatic wait_drained();
		while (rx_q.size() != 0 || tx_exp_q.size() != 0 || bus_exp_q.size() != 0) begin
			@(posedge clock_i);
		end
		repeat (4) @(posedge clock_i);
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED with %0d errors", tests_run, name,
				errors - start_errors);
		end
	endtask

	// ----------------------------------------------------------------------
	// host fifo model and bus monitor
	// ----------------------------------------------------------------------
	always @(negedge clock_i) begin
		rx_empty_i = (rx_q.size() == 0);
		rx_data_i  = (rx_q.size() != 0) ? rx_q[0] : '0;
		tx_full_i  = ({$random(seed)} % 4) == 0;
	end

	always @(posedge clock_i) begin
		if (resetn_i && rx_read_o) begin
			expect_true(!rx_empty_i && rx_q.size() != 0, "rx_read_o raised on an empty fifo");
			if (rx_q.size() != 0) begin
				void'(rx_q.pop_front());
			end
		end
	end

	always @(posedge clock_i) begin
		if (resetn_i && tx_write_o) begin
			tx_count++;
			expect_true(!tx_full_i, "tx_write_o raised on a full fifo");
			expect_true(tx_exp_q.size() != 0, "tx word written with none expected");
			if (tx_exp_q.size() != 0) begin
				tx_expected = tx_exp_q.pop_front();
				check_value("tx_data_o", tx_data_o, tx_expected);
			end
		end
	end

	always @(posedge clock_i) begin
		if (resetn_i && clear_o) begin
			clear_count++;
		end
		if (resetn_i && req_o) begin
			bus_count++;
			expect_true(bus_exp_q.size() != 0, "bus request with none expected");
			if (bus_exp_q.size() != 0) begin
				bus_expected = bus_exp_q.pop_front();
				if (bus_expected.is_cfg) begin
					check_value("reqdev_o", reqdev_o, bus_expected.dev);
					check_value("data_o", data_o, bus_expected.data);
				end else begin
					check_value("reqdev_o", reqdev_o, '0);
					check_value("rw_o", rw_o, bus_expected.rw);
					check_value("add_o", add_o, bus_expected.addr);
					if (bus_expected.rw) begin
						check_value("data_o", data_o, bus_expected.data);
					end
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	task automatic test_purge_sync();
		int                start_errors;
		logic [WORD_W-1:0] word;
		start_errors = errors;
		// stale words read and dropped by the purge
		repeat (8) begin
			rx_q.push_back($random(seed));
			repeat (20) @(posedge clock_i);
		end
		wait_drained();
		repeat (PURGE_CYCLES + 20) @(posedge clock_i);
		expect_true(tx_count == 0, "reply seen during the purge");
		repeat (SYNC_WORDS) begin
			word = $random(seed);
			if (word == KEY_SYNC) begin
				word = ~word;
			end
			rx_q.push_back(word);
			expect_tx(word ^ XOR_SYNC);
		end
		// key ends the exchange without an echo
		rx_q.push_back(KEY_SYNC);
		wait_drained();
		report_test("purge and sync", start_errors);
	endtask

	task automatic run_commands(input int kind, input int num, input string name);
		int                start_errors;
		int                n;
		int                pick;
		int                count;
		logic [ADDR_W-1:0] addr;
		start_errors = errors;
		for (n = 0; n < num; n++) begin
			pick  = (kind == KIND_MIXED) ? int'({$random(seed)} % 3) : kind;
			addr  = pick_address();
			count = 1 + int'({$random(seed)} % 8);
			case (pick)
				KIND_WRITE: queue_write(addr, count);
				KIND_READ:  queue_read(addr, count);
				default:    queue_config();
			endcase
		end
		wait_drained();
		if (kind == KIND_CONFIG) begin
			expect_true(responder_i.cfg_count == cfg_sent, "config count at the memory is wrong");
		end
		if (kind == KIND_MIXED) begin
			expect_true(tx_count == tx_pushed, "tx word count differs from the model");
			expect_true(bus_count == bus_pushed, "bus request count differs from the model");
			expect_true(clear_count == bus_pushed - cfg_sent,
				"clear_o pulse count differs from the number of memory accesses");
		end
		report_test(name, start_errors);
	endtask

	task automatic test_error();
		int                start_errors;
		int                tx_before;
		int                bus_before;
		int                i;
		logic [WORD_W-1:0] word;
		start_errors = errors;
		word = $random(seed);
		if (word == '0) begin
			word = 32'h1;
		end
		rx_q.push_back(word);
		// a full write behind the bad terminator stays unread
		rx_q.push_back('0);
		rx_q.push_back(32'h0000_1000);
		rx_q.push_back(32'h0000_0100);
		rx_q.push_back(32'h1234_5678);
		while (!exception_o) @(posedge clock_i);
		tx_before  = tx_count;
		bus_before = bus_count;
		for (i = 0; i < 200; i++) begin
			@(posedge clock_i);
			expect_true(exception_o, "exception_o fell before reset");
		end
		expect_true(rx_q.size() == 4, "words were read after the exception");
		expect_true(tx_count == tx_before && bus_count == bus_before,
			"bus request or tx word seen after the exception");
		@(negedge clock_i);
		resetn_i = 1'b0;
		rx_q.delete();
		repeat (RESET_CYCLES) @(negedge clock_i);
		check_value("exception_o", exception_o, '0);
		resetn_i = 1'b1;
		report_test("error", start_errors);
	endtask

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		clock_i    = 1'b0;
		resetn_i   = 1'b0;
		rx_empty_i = 1'b1;
		tx_full_i  = 1'b0;
		rx_data_i  = '0;
		repeat (RESET_CYCLES) @(negedge clock_i);
		resetn_i = 1'b1;
		test_purge_sync();
		run_commands(KIND_WRITE, NUM_WRITES, "random writes");
		run_commands(KIND_READ, NUM_READS, "random reads");
		run_commands(KIND_CONFIG, NUM_CONFIGS, "config");
		run_commands(KIND_MIXED, NUM_MIXED, "back-pressure");
		test_error();
		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* comm_controller.f */
src/comm_pkg.sv
src/host_link.sv
src/command_sequencer.sv
src/mem_port.sv
src/comm_controller.sv
testbench/mem_responder.sv
testbench/comm_controller_tb.sv
